// File: cce_cfg.svh
// Width, block size, credit and timeout settings for the hybrid CCE request path
`ifndef CCE_CFG_SVH
`define CCE_CFG_SVH

// Message field widths
`define CCE_PADDR_WIDTH 40
`define CCE_DATA_WIDTH 64
`define CCE_LCE_ID_WIDTH 4

// Cache block size in bytes
`define CCE_BLOCK_BYTES 64

// Memory network credits
`define CCE_MEM_CREDITS 4

// Simulation run length, in cycles per test vector
`define CCE_NUM_VECTORS 20
`define CCE_TIMEOUT (`CCE_NUM_VECTORS * 40)

`endif

// File: cce_pkg.sv
// Shared types, encodings and message formats for the hybrid CCE request path
`include "cce_cfg.svh"

package cce_pkg;

  typedef logic [`CCE_PADDR_WIDTH-1:0]  paddr_t;
  typedef logic [`CCE_DATA_WIDTH-1:0]   data_t;
  typedef logic [`CCE_LCE_ID_WIDTH-1:0] lce_id_t;

  // log2 of the byte count
  typedef logic [2:0] msg_size_t;

  typedef enum logic [1:0] {
    e_req_rd    = 2'b00,
    e_req_wb    = 2'b01,
    e_req_uc_rd = 2'b10,
    e_req_uc_wr = 2'b11
  } lce_req_type_e;

  typedef enum logic [1:0] {
    e_mem_rd    = 2'b00,
    e_mem_wr    = 2'b01,
    e_mem_uc_rd = 2'b10,
    e_mem_uc_wr = 2'b11
  } mem_cmd_type_e;

  // Coherent pipe
  typedef enum logic {
    e_ready = 1'b0,
    e_send  = 1'b1
  } pipe_state_e;

  typedef struct packed {
    lce_req_type_e msg_type;
    paddr_t        addr;
    lce_id_t       lce_id;
    msg_size_t     size;
    data_t         data;
  } lce_req_s;

  typedef struct packed {
    mem_cmd_type_e msg_type;
    paddr_t        addr;
    lce_id_t       lce_id;
    msg_size_t     size;
    data_t         data;
  } mem_cmd_s;

endpackage

// File: cce_req_split.sv
// LCE request splitter that routes each request to the uncacheable or coherent pipe
`timescale 1ns/10ps

module cce_req_split (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  cce_pkg::lce_req_s lce_req_i,
  input  logic              lce_req_v_i,
  output logic              lce_req_ready_o,
  output cce_pkg::lce_req_s uc_req_o,
  output logic              uc_req_v_o,
  input  logic              uc_req_ready_i,
  output cce_pkg::lce_req_s coh_req_o,
  output logic              coh_req_v_o,
  input  logic              coh_req_ready_i
);

  cce_pkg::lce_req_s req_r;
  logic              req_v_r;
  logic              route_uc_r;
  logic              is_uc;
  logic              req_taken;
  logic              req_accept;

  assign is_uc = (lce_req_i.msg_type == cce_pkg::e_req_uc_rd) ||
                 (lce_req_i.msg_type == cce_pkg::e_req_uc_wr);

  // Entry leaves on the ready of the output it was steered to
  assign req_taken       = req_v_r & (route_uc_r ? uc_req_ready_i : coh_req_ready_i);
  assign lce_req_ready_o = ~req_v_r | req_taken;
  assign req_accept      = lce_req_v_i & lce_req_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      req_v_r    <= 1'b0;
      route_uc_r <= 1'b0;
    end else if (req_accept) begin
      req_v_r    <= 1'b1;
      route_uc_r <= is_uc;
    end else if (req_taken) begin
      req_v_r    <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_accept) begin
      req_r <= lce_req_i;
    end
  end

  assign uc_req_o    = req_r;
  assign coh_req_o   = req_r;
  assign uc_req_v_o  = req_v_r & route_uc_r;
  assign coh_req_v_o = req_v_r & ~route_uc_r;

endmodule

// File: cce_uc_pipe.sv
// Uncacheable pipe that turns an uncacheable LCE request into a memory command
`timescale 1ns/10ps

module cce_uc_pipe (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  cce_pkg::lce_req_s req_i,
  input  logic              req_v_i,
  output logic              req_ready_o,
  output cce_pkg::mem_cmd_s cmd_o,
  output logic              cmd_v_o,
  input  logic              cmd_ready_i
);

  cce_pkg::mem_cmd_s cmd_r;
  cce_pkg::mem_cmd_s cmd_next;
  logic              cmd_v_r;
  logic              req_accept;
  logic              is_wr;

  assign req_ready_o = ~cmd_v_r | cmd_ready_i;
  assign req_accept  = req_v_i & req_ready_o;
  assign is_wr       = (req_i.msg_type == cce_pkg::e_req_uc_wr);

  // Address, size and LCE id go to memory as given
  always_comb begin
    cmd_next.msg_type = is_wr ? cce_pkg::e_mem_uc_wr : cce_pkg::e_mem_uc_rd;
    cmd_next.addr     = req_i.addr;
    cmd_next.lce_id   = req_i.lce_id;
    cmd_next.size     = req_i.size;
    cmd_next.data     = is_wr ? req_i.data : '0;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cmd_v_r <= 1'b0;
    end else if (req_accept) begin
      cmd_v_r <= 1'b1;
    end else if (cmd_ready_i) begin
      cmd_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_accept) begin
      cmd_r <= cmd_next;
    end
  end

  assign cmd_o   = cmd_r;
  assign cmd_v_o = cmd_v_r;

endmodule

// File: cce_coh_pipe.sv
// Coherent pipe that turns a cacheable LCE request into a block-aligned memory command
`timescale 1ns/10ps
`include "cce_cfg.svh"

module cce_coh_pipe (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  cce_pkg::lce_req_s req_i,
  input  logic              req_v_i,
  output logic              req_ready_o,
  output cce_pkg::mem_cmd_s cmd_o,
  output logic              cmd_v_o,
  input  logic              cmd_ready_i
);

  localparam int block_offset_lp = $clog2(`CCE_BLOCK_BYTES);

  cce_pkg::pipe_state_e state_r;
  cce_pkg::mem_cmd_s    cmd_r;
  cce_pkg::mem_cmd_s    cmd_next;
  logic                 req_accept;
  logic                 is_wb;

  // A new request may enter while the held command drains
  assign req_ready_o = (state_r == cce_pkg::e_ready) | cmd_ready_i;
  assign req_accept  = req_v_i & req_ready_o;
  assign is_wb       = (req_i.msg_type == cce_pkg::e_req_wb);

  always_comb begin
    cmd_next.msg_type = is_wb ? cce_pkg::e_mem_wr : cce_pkg::e_mem_rd;
    cmd_next.addr     = req_i.addr & ~cce_pkg::paddr_t'(`CCE_BLOCK_BYTES - 1);
    cmd_next.lce_id   = req_i.lce_id;
    // Always a full block
    cmd_next.size     = cce_pkg::msg_size_t'(block_offset_lp);
    cmd_next.data     = is_wb ? req_i.data : '0;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= cce_pkg::e_ready;
    end else begin
      case (state_r)
        cce_pkg::e_ready: begin
          if (req_accept) begin
            state_r <= cce_pkg::e_send;
          end
        end
        cce_pkg::e_send: begin
          if (cmd_ready_i && !req_accept) begin
            state_r <= cce_pkg::e_ready;
          end
        end
        default: begin
          state_r <= cce_pkg::e_ready;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_accept) begin
      cmd_r <= cmd_next;
    end
  end

  assign cmd_o   = cmd_r;
  assign cmd_v_o = (state_r == cce_pkg::e_send);

endmodule

// File: cce_mem_cmd_arb.sv
// Round-robin memory command arbiter with output register and memory credit counter
`timescale 1ns/10ps
`include "cce_cfg.svh"

module cce_mem_cmd_arb (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  cce_pkg::mem_cmd_s uc_cmd_i,
  input  logic              uc_cmd_v_i,
  output logic              uc_cmd_ready_o,
  input  cce_pkg::mem_cmd_s coh_cmd_i,
  input  logic              coh_cmd_v_i,
  output logic              coh_cmd_ready_o,
  output cce_pkg::mem_cmd_s mem_cmd_o,
  output logic              mem_cmd_v_o,
  input  logic              mem_cmd_ready_i,
  input  logic              mem_resp_v_i
);

  localparam int credit_width_lp = $clog2(`CCE_MEM_CREDITS + 1);

  cce_pkg::mem_cmd_s          mem_cmd_r;
  logic                       mem_cmd_v_r;
  logic                       last_grant_coh_r;
  logic [credit_width_lp-1:0] credit_count_r;
  logic                       cmd_sent;
  logic                       credit_return;
  logic                       out_free;
  logic                       credit_room;
  logic                       grant_uc;
  logic                       grant_coh;
  logic                       grant_v;

  assign cmd_sent      = mem_cmd_v_r & mem_cmd_ready_i;
  assign credit_return = mem_resp_v_i & (credit_count_r != '0);
  assign out_free      = ~mem_cmd_v_r | mem_cmd_ready_i;

  // A command parked in the output register already holds a credit
  assign credit_room = (int'(credit_count_r) + int'(mem_cmd_v_r)) < `CCE_MEM_CREDITS;

  // Priority goes to the input that was not granted last
  assign grant_uc  = out_free & credit_room & uc_cmd_v_i &
                     (~coh_cmd_v_i | last_grant_coh_r);
  assign grant_coh = out_free & credit_room & coh_cmd_v_i &
                     (~uc_cmd_v_i | ~last_grant_coh_r);
  assign grant_v   = grant_uc | grant_coh;

  assign uc_cmd_ready_o  = grant_uc;
  assign coh_cmd_ready_o = grant_coh;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mem_cmd_v_r      <= 1'b0;
      last_grant_coh_r <= 1'b0;
    end else begin
      if (grant_v) begin
        mem_cmd_v_r      <= 1'b1;
        last_grant_coh_r <= grant_coh;
      end else if (cmd_sent) begin
        mem_cmd_v_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant_uc) begin
      mem_cmd_r <= uc_cmd_i;
    end else if (grant_coh) begin
      mem_cmd_r <= coh_cmd_i;
    end
  end

  // Send and return in one cycle cancel out
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_count_r <= '0;
    end else begin
      case ({cmd_sent, credit_return})
        2'b10:   credit_count_r <= credit_count_r + 1'b1;
        2'b01:   credit_count_r <= credit_count_r - 1'b1;
        default: credit_count_r <= credit_count_r;
      endcase
    end
  end

  assign mem_cmd_o   = mem_cmd_r;
  assign mem_cmd_v_o = mem_cmd_v_r;

endmodule

// File: cce_hybrid.sv
// Hybrid CCE request path from LCE request to memory command
`timescale 1ns/10ps

module cce_hybrid (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  cce_pkg::lce_req_s lce_req_i,
  input  logic              lce_req_v_i,
  output logic              lce_req_ready_o,
  output cce_pkg::mem_cmd_s mem_cmd_o,
  output logic              mem_cmd_v_o,
  input  logic              mem_cmd_ready_i,
  input  logic              mem_resp_v_i
);

  cce_pkg::lce_req_s uc_req;
  logic              uc_req_v;
  logic              uc_req_ready;
  cce_pkg::lce_req_s coh_req;
  logic              coh_req_v;
  logic              coh_req_ready;

  cce_pkg::mem_cmd_s uc_cmd;
  logic              uc_cmd_v;
  logic              uc_cmd_ready;
  cce_pkg::mem_cmd_s coh_cmd;
  logic              coh_cmd_v;
  logic              coh_cmd_ready;

  cce_req_split u_split (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .lce_req_i       (lce_req_i),
    .lce_req_v_i     (lce_req_v_i),
    .lce_req_ready_o (lce_req_ready_o),
    .uc_req_o        (uc_req),
    .uc_req_v_o      (uc_req_v),
    .uc_req_ready_i  (uc_req_ready),
    .coh_req_o       (coh_req),
    .coh_req_v_o     (coh_req_v),
    .coh_req_ready_i (coh_req_ready)
  );

  cce_uc_pipe u_uc_pipe (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (uc_req),
    .req_v_i     (uc_req_v),
    .req_ready_o (uc_req_ready),
    .cmd_o       (uc_cmd),
    .cmd_v_o     (uc_cmd_v),
    .cmd_ready_i (uc_cmd_ready)
  );

  cce_coh_pipe u_coh_pipe (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (coh_req),
    .req_v_i     (coh_req_v),
    .req_ready_o (coh_req_ready),
    .cmd_o       (coh_cmd),
    .cmd_v_o     (coh_cmd_v),
    .cmd_ready_i (coh_cmd_ready)
  );

  cce_mem_cmd_arb u_arb (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .uc_cmd_i        (uc_cmd),
    .uc_cmd_v_i      (uc_cmd_v),
    .uc_cmd_ready_o  (uc_cmd_ready),
    .coh_cmd_i       (coh_cmd),
    .coh_cmd_v_i     (coh_cmd_v),
    .coh_cmd_ready_o (coh_cmd_ready),
    .mem_cmd_o       (mem_cmd_o),
    .mem_cmd_v_o     (mem_cmd_v_o),
    .mem_cmd_ready_i (mem_cmd_ready_i),
    .mem_resp_v_i    (mem_resp_v_i)
  );

endmodule

// File: cce_hybrid_asserts.sv
// Protocol assertions for the hybrid CCE memory command port and credit limit
`timescale 1ns/10ps
`include "cce_cfg.svh"

module cce_hybrid_asserts (
  input logic                                     clk_i,
  input logic                                     rst_n_i,
  input cce_pkg::mem_cmd_s                        mem_cmd_i,
  input logic                                     mem_cmd_v_i,
  input logic                                     mem_cmd_ready_i,
  input logic [$clog2(`CCE_MEM_CREDITS + 1)-1:0]  credit_count_i,
  input logic                                     grant_v_i
);

  int assert_errors;

  initial assert_errors = 0;

  // Held command must not change under back-pressure
  cmd_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_cmd_v_i && !mem_cmd_ready_i |=> mem_cmd_v_i && $stable(mem_cmd_i))
    else begin
      $error("mem_cmd_o changed or dropped valid while stalled");
      assert_errors++;
    end

  idle_after_reset: assert property (@(posedge clk_i) !rst_n_i |=> !mem_cmd_v_i)
    else begin
      $error("mem_cmd_v_o high right after reset");
      assert_errors++;
    end

  // A valid output command with every credit in use means one extra grant
  no_grant_without_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credit_count_i == `CCE_MEM_CREDITS |-> !grant_v_i && !mem_cmd_v_i)
    else begin
      $error("arbiter granted or held a command with all credits outstanding");
      assert_errors++;
    end

endmodule

bind cce_hybrid cce_hybrid_asserts u_asserts (
  .clk_i           (clk_i),
  .rst_n_i         (rst_n_i),
  .mem_cmd_i       (mem_cmd_o),
  .mem_cmd_v_i     (mem_cmd_v_o),
  .mem_cmd_ready_i (mem_cmd_ready_i),
  .credit_count_i  (u_arb.credit_count_r),
  .grant_v_i       (u_arb.grant_v)
);

// File: tb_cce_hybrid.sv
// Testbench for the hybrid CCE request path, driven from a test data file
`timescale 1ns/10ps
`include "cce_cfg.svh"

module tb_cce_hybrid;

  logic              clk_i;
  logic              rst_n_i;
  cce_pkg::lce_req_s lce_req_i;
  logic              lce_req_v_i;
  logic              lce_req_ready_o;
  cce_pkg::mem_cmd_s mem_cmd_o;
  logic              mem_cmd_v_o;
  logic              mem_cmd_ready_i;
  logic              mem_resp_v_i;

  logic [63:0]       vec_mem [0:8*`CCE_NUM_VECTORS-1];
  cce_pkg::mem_cmd_s uc_q[$];
  cce_pkg::mem_cmd_s coh_q[$];
  int                error_count;
  int                tests_run;
  int                tests_failed;
  int                cmd_count;
  int                resp_owed;
  int                cycle_count;
  logic              auto_resp;
  logic              rand_ready;
  logic [31:0]       lfsr;

  cce_hybrid u_cce_hybrid (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .lce_req_i       (lce_req_i),
    .lce_req_v_i     (lce_req_v_i),
    .lce_req_ready_o (lce_req_ready_o),
    .mem_cmd_o       (mem_cmd_o),
    .mem_cmd_v_o     (mem_cmd_v_o),
    .mem_cmd_ready_i (mem_cmd_ready_i),
    .mem_resp_v_i    (mem_resp_v_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic check_field(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  // Called 1 ns after a rising edge, returns 1 ns after the accepting edge
  task automatic send_req(input int row);
    cce_pkg::lce_req_s req;
    cce_pkg::mem_cmd_s exp;
    req.msg_type = cce_pkg::lce_req_type_e'(vec_mem[8*row][1:0]);
    req.addr     = vec_mem[8*row+1][`CCE_PADDR_WIDTH-1:0];
    req.lce_id   = vec_mem[8*row+2][`CCE_LCE_ID_WIDTH-1:0];
    req.size     = vec_mem[8*row+3][2:0];
    req.data     = vec_mem[8*row+4];
    exp.msg_type = cce_pkg::mem_cmd_type_e'(vec_mem[8*row+5][1:0]);
    exp.addr     = vec_mem[8*row+6][`CCE_PADDR_WIDTH-1:0];
    exp.lce_id   = req.lce_id;
    exp.size     = vec_mem[8*row+7][2:0];
    // Only writes carry data to memory
    exp.data = (exp.msg_type == cce_pkg::e_mem_wr || exp.msg_type == cce_pkg::e_mem_uc_wr) ?
               req.data : '0;
    if (exp.msg_type == cce_pkg::e_mem_uc_rd || exp.msg_type == cce_pkg::e_mem_uc_wr) begin
      uc_q.push_back(exp);
    end else begin
      coh_q.push_back(exp);
    end
    lce_req_i   = req;
    lce_req_v_i = 1'b1;
    @(posedge clk_i);
    while (!lce_req_ready_o) @(posedge clk_i);
    #1;
    lce_req_v_i = 1'b0;
  endtask

  task automatic wait_drain();
    while (uc_q.size() != 0 || coh_q.size() != 0 || resp_owed != 0) @(posedge clk_i);
    repeat (3) @(posedge clk_i);
    #1;
  endtask

  task automatic finish_test(input string name, input int errs_at_start);
    tests_run++;
    if (error_count == errs_at_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, error_count - errs_at_start);
    end
  endtask

  // Memory side: ready and response strobes change 1 ns after the edge
  always @(posedge clk_i) begin : mem_side
    logic use_rand;
    use_rand = rand_ready;
    #1;
    if (use_rand) begin
      lfsr            = lfsr_next(lfsr);
      mem_cmd_ready_i = lfsr[0];
    end else begin
      mem_cmd_ready_i = 1'b1;
    end
    if (resp_owed > 0) begin
      mem_resp_v_i = 1'b1;
      resp_owed--;
    end else begin
      mem_resp_v_i = 1'b0;
    end
  end

  always @(posedge clk_i) begin : monitor
    cce_pkg::mem_cmd_s exp;
    logic              is_uc;
    if (rst_n_i && mem_cmd_v_o && mem_cmd_ready_i) begin
      cmd_count++;
      if (auto_resp) begin
        resp_owed++;
      end
      is_uc = (mem_cmd_o.msg_type == cce_pkg::e_mem_uc_rd) ||
              (mem_cmd_o.msg_type == cce_pkg::e_mem_uc_wr);
      assert ((is_uc ? uc_q.size() : coh_q.size()) > 0) else begin
        $display("command on mem_cmd_o with no matching request outstanding");
        error_count++;
      end
      if ((is_uc ? uc_q.size() : coh_q.size()) > 0) begin
        exp = is_uc ? uc_q.pop_front() : coh_q.pop_front();
        check_field("mem_cmd_o.msg_type", 64'(mem_cmd_o.msg_type), 64'(exp.msg_type));
        check_field("mem_cmd_o.addr", 64'(mem_cmd_o.addr), 64'(exp.addr));
        check_field("mem_cmd_o.lce_id", 64'(mem_cmd_o.lce_id), 64'(exp.lce_id));
        check_field("mem_cmd_o.size", 64'(mem_cmd_o.size), 64'(exp.size));
        check_field("mem_cmd_o.data", mem_cmd_o.data, exp.data);
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= `CCE_TIMEOUT) begin
      $display("timeout after %0d cycles with commands still missing", cycle_count);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    int errs;
    int base;
    rst_n_i         = 1'b0;
    lce_req_i       = '0;
    lce_req_v_i     = 1'b0;
    mem_cmd_ready_i = 1'b1;
    mem_resp_v_i    = 1'b0;
    error_count     = 0;
    tests_run       = 0;
    tests_failed    = 0;
    cmd_count       = 0;
    resp_owed       = 0;
    cycle_count     = 0;
    auto_resp       = 1'b1;
    rand_ready      = 1'b0;
    lfsr            = 32'h51a786bd;
    $readmemh("cce_testdata.txt", vec_mem);
    assert (!$isunknown(vec_mem[8*`CCE_NUM_VECTORS-1])) else begin
      $display("test data file cce_testdata.txt could not be read completely");
      error_count++;
    end
    repeat (2) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    errs = error_count;
    repeat (10) begin
      @(posedge clk_i);
      check_field("mem_cmd_v_o", 64'(mem_cmd_v_o), 64'h0);
      check_field("lce_req_ready_o", 64'(lce_req_ready_o), 64'h1);
    end
    #1;
    finish_test("idle_after_reset", errs);

    errs = error_count;
    for (int r = 0; r < `CCE_NUM_VECTORS; r++) begin
      if (vec_mem[8*r][1]) send_req(r);
    end
    wait_drain();
    finish_test("uncacheable_mapping", errs);

    errs = error_count;
    for (int r = 0; r < `CCE_NUM_VECTORS; r++) begin
      if (!vec_mem[8*r][1]) send_req(r);
    end
    wait_drain();
    finish_test("coherent_mapping", errs);

    errs = error_count;
    rand_ready = 1'b1;
    for (int r = 0; r < `CCE_NUM_VECTORS; r++) begin
      send_req(r);
    end
    wait_drain();
    rand_ready = 1'b0;
    finish_test("mixed_backpressure", errs);

    // Credits run out after four commands with no responses
    errs      = error_count;
    auto_resp = 1'b0;
    base      = cmd_count;
    for (int r = 0; r < 6; r++) begin
      send_req(r);
    end
    while (cmd_count < base + 4) @(posedge clk_i);
    repeat (2) @(posedge clk_i);
    repeat (16) begin
      @(posedge clk_i);
      check_field("mem_cmd_v_o", 64'(mem_cmd_v_o), 64'h0);
    end
    check_field("command count", 64'(cmd_count - base), 64'd4);
    for (int k = 5; k <= 6; k++) begin
      resp_owed++;
      while (cmd_count < base + k) @(posedge clk_i);
      repeat (16) @(posedge clk_i);
      check_field("command count", 64'(cmd_count - base), 64'(k));
    end
    resp_owed += 4;
    auto_resp = 1'b1;
    wait_drain();
    finish_test("credit_limit", errs);

    error_count += u_cce_hybrid.u_asserts.assert_errors;
    $display("tests run %0d, tests failed %0d, errors %0d, commands %0d",
             tests_run, tests_failed, error_count, cmd_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: cce_testdata.txt
// req_type req_addr lce_id req_size req_data, then the expected exp_type exp_addr exp_size
// Types: 0 rd, 1 wb, 2 uc_rd, 3 uc_wr (same codes for the memory command)
2 0000001008 1 3 0000000000000000 2 0000001008 3
0 0000002044 2 3 0000000000000000 0 0000002040 6
3 0000003010 3 2 00000000cafef00d 3 0000003010 2
1 000000407f 4 3 1122334455667788 1 0000004040 6
2 ffffffff00 5 0 00000000deadbeef 2 ffffffff00 0
0 00abcdef12 6 3 0123456789abcdef 0 00abcdef00 6
3 0000000fff 7 0 00000000000000a5 3 0000000fff 0
1 8000000000 8 3 a5a5a5a5a5a5a5a5 1 8000000000 6
3 0000010004 9 1 0000000012345678 3 0000010004 1
1 00000200c8 a 3 fedcba9876543210 1 00000200c0 6
2 0000030007 b 0 0000000000000000 2 0000030007 0
0 12345678ff c 3 0000000000000000 0 12345678c0 6
3 0000040100 d 3 0102030405060708 3 0000040100 3
0 0000050001 e 3 0000000000000000 0 0000050000 6
2 7fffffffff f 2 0000000000000000 2 7fffffffff 2
1 fffffffffe 0 3 0f0f0f0f0f0f0f0f 1 ffffffffc0 6
3 0000060020 1 3 ffffffffffffffff 3 0000060020 3
1 0000070080 2 3 1357924680aceace 1 0000070080 6
2 0000080018 3 1 0000000000000000 2 0000080018 1
0 00000900bf 4 3 0000000000000000 0 0000090080 6

// File: files.f
+incdir+.
cce_pkg.sv
cce_req_split.sv
cce_uc_pipe.sv
cce_coh_pipe.sv
cce_mem_cmd_arb.sv
cce_hybrid.sv
cce_hybrid_asserts.sv
tb_cce_hybrid.sv
